/* common/radio_ctrl_pkg.sv */
// Register map, sizes and bus structs for the radio control plane
// Imported by every RTL block and by the testbench
`default_nettype none

package radio_ctrl_pkg;

   ////////////////////
   // Sizes
   ////////////////////
   localparam int AXIL_ADDR_W     = 8;
   localparam int AXIL_DATA_W     = 32;
   localparam int SPI_WORD_W      = 16;
   localparam int SPI_DIV_W       = 8;    // Half-period = div+1 bus cycles
   localparam int NUM_SPI_TARGETS = 2;    // 0 codec, 1 PLL
   localparam int NUM_CHANNELS    = 2;
   localparam int ATR_W           = 8;    // One switch word per state
   localparam int MISC_W          = 8;
   localparam int HOLDOFF_CYCLES  = 64;   // Bus cycles after lock

   ////////////////////
   // Register map
   ////////////////////
   localparam logic [AXIL_ADDR_W-1:0] REG_SPI_DATA = 8'h00; // Wr starts xfer, rd last rx
   localparam logic [AXIL_ADDR_W-1:0] REG_SPI_CFG  = 8'h04; // [0] target, [15:8] div
   localparam logic [AXIL_ADDR_W-1:0] REG_STATUS   = 8'h08; // [0] busy, [1] pll lock
   localparam logic [AXIL_ADDR_W-1:0] REG_ATR0     = 8'h10;
   localparam logic [AXIL_ADDR_W-1:0] REG_ATR1     = 8'h14;
   localparam logic [AXIL_ADDR_W-1:0] REG_MISC     = 8'h18;

   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_SLVERR = 2'd2;

   ////////////////////
   // Bus structs
   ////////////////////
   typedef struct packed {
      logic [AXIL_ADDR_W-1:0]   awaddr;
      logic                     awvalid;
      logic [AXIL_DATA_W-1:0]   wdata;
      logic [AXIL_DATA_W/8-1:0] wstrb;
      logic                     wvalid;
      logic                     bready;
      logic [AXIL_ADDR_W-1:0]   araddr;
      logic                     arvalid;
      logic                     rready;
   } axil_m2s_t;

   typedef struct packed {
      logic                   awready;
      logic                   wready;
      logic [1:0]             bresp;
      logic                   bvalid;
      logic                   arready;
      logic [AXIL_DATA_W-1:0] rdata;
      logic [1:0]             rresp;
      logic                   rvalid;
   } axil_s2m_t;

   // One SPI transfer request
   typedef struct packed {
      logic [SPI_WORD_W-1:0] data;
      logic                  target;
      logic [SPI_DIV_W-1:0]  clk_div;
   } spi_cmd_t;

   // Switch words of one channel, idle in the top byte
   typedef struct packed {
      logic [ATR_W-1:0] idle;
      logic [ATR_W-1:0] rx_only;
      logic [ATR_W-1:0] tx_only;
      logic [ATR_W-1:0] full_duplex;
   } atr_cfg_t;

endpackage

`default_nettype wire

/* flist.f */
common/radio_ctrl_pkg.sv
logic/reset_holdoff.sv
settings/settings_regs.sv
spi/spi_master.sv
logic/fe_atr_ctrl.sv
logic/radio_ctrl_top.sv
tb/radio_ctrl_sva.sv
tb/tb_radio_ctrl.sv

/* logic/fe_atr_ctrl.sv */
// Front-end switch control for one channel
// Picks the configured word for the current run state and registers it
`timescale 1ns/1ns
`default_nettype none

module fe_atr_ctrl (
   input  wire                                bus_clk,
   input  wire                                bus_rst,
   input  wire radio_ctrl_pkg::atr_cfg_t      atr_cfg,
   input  wire                                run_rx,
   input  wire                                run_tx,
   output logic [radio_ctrl_pkg::ATR_W-1:0]   atr_out
);
   import radio_ctrl_pkg::*;

   logic [ATR_W-1:0] atr_sel;

   // State select
   always_comb begin
      case ({run_tx, run_rx})
         2'b00:   atr_sel = atr_cfg.idle;
         2'b01:   atr_sel = atr_cfg.rx_only;
         2'b10:   atr_sel = atr_cfg.tx_only;
         default: atr_sel = atr_cfg.full_duplex;   // Both running
      endcase
   end

   // Registered so the switch pins never glitch
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         atr_out <= '0;
      end else begin
         atr_out <= atr_sel;
      end
   end

endmodule

`default_nettype wire

/* logic/radio_ctrl_top.sv */
// Control plane top for the two-channel radio board
// Ties reset hold-off, settings slave, SPI master and ATR control to the pins
`timescale 1ns/1ns
`default_nettype none

module radio_ctrl_top (
   input  wire                                      bus_clk,
   input  wire                                      reset_global,
   input  wire                                      locked,
   input  wire                                      pll_lock,
   input  wire radio_ctrl_pkg::axil_m2s_t           axil_req,
   output radio_ctrl_pkg::axil_s2m_t                axil_rsp,
   // Codec SPI
   input  wire                                      cat_miso,
   output logic                                     cat_sen,
   output logic                                     cat_mosi,
   output logic                                     cat_sclk,
   // PLL SPI, write only
   output logic                                     pll_sen,
   output logic                                     pll_mosi,
   output logic                                     pll_sclk,
   // Channel run state
   input  wire [radio_ctrl_pkg::NUM_CHANNELS-1:0]   run_rx,
   input  wire [radio_ctrl_pkg::NUM_CHANNELS-1:0]   run_tx,
   output logic [radio_ctrl_pkg::ATR_W-1:0]         fe_atr0,
   output logic [radio_ctrl_pkg::ATR_W-1:0]         fe_atr1,
   output logic [radio_ctrl_pkg::MISC_W-1:0]        misc_outs
);
   import radio_ctrl_pkg::*;

   logic                       bus_rst;
   spi_cmd_t                   spi_cmd;
   logic                       spi_start, spi_busy;
   logic [SPI_WORD_W-1:0]      spi_rx_data;
   logic                       sclk, mosi;
   logic [NUM_SPI_TARGETS-1:0] sen;
   atr_cfg_t                   atr_cfg0, atr_cfg1;

   ////////////////////
   // Reset and settings
   ////////////////////
   reset_holdoff i_reset_holdoff (
      .bus_clk(bus_clk), .reset_global(reset_global), .locked(locked), .bus_rst(bus_rst)
   );

   settings_regs i_settings_regs (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .axil_req(axil_req), .axil_rsp(axil_rsp),
      .spi_busy(spi_busy), .spi_rx_data(spi_rx_data), .pll_lock(pll_lock),
      .spi_cmd(spi_cmd), .spi_start(spi_start),
      .atr_cfg0(atr_cfg0), .atr_cfg1(atr_cfg1), .misc_outs(misc_outs)
   );

   ////////////////////
   // SPI
   ////////////////////
   spi_master i_spi_master (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .spi_cmd(spi_cmd), .spi_start(spi_start),
      .miso(cat_miso),                          // PLL has no miso
      .sclk(sclk), .mosi(mosi), .sen(sen),
      .spi_busy(spi_busy), .spi_rx_data(spi_rx_data)
   );

   assign cat_sen  = sen[0];
   assign cat_mosi = ~sen[0] & mosi;            // Idle target sees low lines
   assign cat_sclk = ~sen[0] & sclk;
   assign pll_sen  = sen[1];
   assign pll_mosi = ~sen[1] & mosi;
   assign pll_sclk = ~sen[1] & sclk;

   ////////////////////
   // Front-end ATR
   ////////////////////
   fe_atr_ctrl atr0 (
      .bus_clk(bus_clk), .bus_rst(bus_rst), .atr_cfg(atr_cfg0),
      .run_rx(run_rx[0]), .run_tx(run_tx[0]), .atr_out(fe_atr0)
   );

   fe_atr_ctrl atr1 (
      .bus_clk(bus_clk), .bus_rst(bus_rst), .atr_cfg(atr_cfg1),
      .run_rx(run_rx[1]), .run_tx(run_tx[1]), .atr_out(fe_atr1)
   );

endmodule

`default_nettype wire

/* logic/reset_holdoff.sv */
// Holds the bus reset until the clock generator has been locked for a while
// bus_rst is active high and released synchronously to bus_clk
`timescale 1ns/1ns
`default_nettype none

module reset_holdoff (
   input  wire  bus_clk,
   input  wire  reset_global,
   input  wire  locked,
   output logic bus_rst
);
   import radio_ctrl_pkg::*;

   logic                              holdoff_clr;  // Global reset or lock lost
   logic [$clog2(HOLDOFF_CYCLES)-1:0] ready_count;
   logic                              clocks_ready;
   logic [1:0]                        rst_sync;     // Release synchronizer

   assign holdoff_clr = reset_global | ~locked;

   // Count bus cycles once lock is stable
   always_ff @(posedge bus_clk or posedge holdoff_clr) begin
      if (holdoff_clr) begin
         ready_count  <= '0;
         clocks_ready <= 1'b0;
      end else if (!clocks_ready) begin
         ready_count  <= ready_count + 1'b1;
         clocks_ready <= (ready_count == HOLDOFF_CYCLES - 1); // Sticky until clear
      end
   end

   // Assert at once, release after two edges
   always_ff @(posedge bus_clk or posedge holdoff_clr) begin
      if (holdoff_clr) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], ~clocks_ready};
      end
   end

   assign bus_rst = rst_sync[1];

endmodule

`default_nettype wire

/* settings/settings_regs.sv */
// AXI4-Lite settings slave with the board configuration registers
// Launches SPI transfers and feeds the ATR and misc outputs
`timescale 1ns/1ns
`default_nettype none

module settings_regs (
   input  wire                                     bus_clk,
   input  wire                                     bus_rst,
   input  wire radio_ctrl_pkg::axil_m2s_t          axil_req,
   output radio_ctrl_pkg::axil_s2m_t               axil_rsp,
   input  wire                                     spi_busy,
   input  wire [radio_ctrl_pkg::SPI_WORD_W-1:0]    spi_rx_data,
   input  wire                                     pll_lock,
   output radio_ctrl_pkg::spi_cmd_t                spi_cmd,
   output logic                                    spi_start,
   output radio_ctrl_pkg::atr_cfg_t                atr_cfg0,
   output radio_ctrl_pkg::atr_cfg_t                atr_cfg1,
   output logic [radio_ctrl_pkg::MISC_W-1:0]       misc_outs
);
   import radio_ctrl_pkg::*;

   logic [SPI_WORD_W-1:0]  spi_data_r;    // Next word to send
   logic                   spi_target_r;
   logic [SPI_DIV_W-1:0]   spi_div_r;
   logic [MISC_W-1:0]      misc_r;
   logic                   aw_rdy, ar_rdy;  // awready/wready share one flop
   logic                   bvalid_r, rvalid_r;
   logic [1:0]             bresp_r, rresp_r;
   logic [AXIL_DATA_W-1:0] rdata_r;
   logic                   wr_fire, rd_fire;
   logic                   wr_hit, rd_hit;
   logic [AXIL_DATA_W-1:0] wr_cur, wr_merge, rd_mux;

   // Byte-lane merge of write data into a register
   function automatic logic [AXIL_DATA_W-1:0] apply_strb(
      input logic [AXIL_DATA_W-1:0]   cur,
      input logic [AXIL_DATA_W-1:0]   wdata,
      input logic [AXIL_DATA_W/8-1:0] strb
   );
      logic [AXIL_DATA_W-1:0] res;
      res = cur;
      for (int i = 0; i < AXIL_DATA_W/8; i++) begin
         if (strb[i]) res[8*i +: 8] = wdata[8*i +: 8];
      end
      return res;
   endfunction

   assign wr_fire = aw_rdy & axil_req.awvalid & axil_req.wvalid;
   assign rd_fire = ar_rdy & axil_req.arvalid;

   ////////////////////
   // Address decode
   ////////////////////
   always_comb begin
      wr_hit = 1'b1;
      wr_cur = '0;
      case (axil_req.awaddr)
         REG_SPI_DATA: begin
            wr_hit = ~(spi_busy | spi_start);   // No restart mid-transfer
            wr_cur[SPI_WORD_W-1:0] = spi_data_r;
         end
         REG_SPI_CFG:  wr_cur[15:0] = {spi_div_r, 7'd0, spi_target_r};
         REG_STATUS:   wr_cur = '0;             // Read only, write ignored
         REG_ATR0:     wr_cur = atr_cfg0;
         REG_ATR1:     wr_cur = atr_cfg1;
         REG_MISC:     wr_cur[MISC_W-1:0] = misc_r;
         default:      wr_hit = 1'b0;
      endcase
      wr_merge = apply_strb(wr_cur, axil_req.wdata, axil_req.wstrb);
   end

   always_comb begin
      rd_hit = 1'b1;
      rd_mux = '0;                              // Unmapped reads give zero
      case (axil_req.araddr)
         REG_SPI_DATA: rd_mux[SPI_WORD_W-1:0] = spi_rx_data;
         REG_SPI_CFG:  rd_mux[15:0] = {spi_div_r, 7'd0, spi_target_r};
         REG_STATUS:   rd_mux[1:0] = {pll_lock, spi_busy};
         REG_ATR0:     rd_mux = atr_cfg0;
         REG_ATR1:     rd_mux = atr_cfg1;
         REG_MISC:     rd_mux[MISC_W-1:0] = misc_r;
         default:      rd_hit = 1'b0;
      endcase
   end

   ////////////////////
   // Handshakes
   ////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         aw_rdy    <= 1'b0;
         ar_rdy    <= 1'b0;
         bvalid_r  <= 1'b0;
         rvalid_r  <= 1'b0;
         bresp_r   <= RESP_OKAY;
         rresp_r   <= RESP_OKAY;
         spi_start <= 1'b0;
      end else begin
         // One-cycle ready pulse, held off while a response waits
         aw_rdy <= ~aw_rdy & axil_req.awvalid & axil_req.wvalid & ~bvalid_r;
         ar_rdy <= ~ar_rdy & axil_req.arvalid & ~rvalid_r;
         spi_start <= wr_fire & wr_hit & (axil_req.awaddr == REG_SPI_DATA);
         if (wr_fire) begin
            bvalid_r <= 1'b1;
            bresp_r  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
         end else if (axil_req.bready) begin
            bvalid_r <= 1'b0;
         end
         if (rd_fire) begin
            rvalid_r <= 1'b1;
            rresp_r  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
         end else if (axil_req.rready) begin
            rvalid_r <= 1'b0;
         end
      end
   end

   always_ff @(posedge bus_clk) begin
      if (rd_fire) rdata_r <= rd_mux;           // Held until rready
   end

   ////////////////////
   // Config registers
   ////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         spi_data_r   <= '0;
         spi_target_r <= 1'b0;
         spi_div_r    <= '0;
         atr_cfg0     <= '0;
         atr_cfg1     <= '0;
         misc_r       <= '0;
         misc_outs    <= '0;
      end else begin
         misc_outs <= misc_r;                   // Extra stage toward the pins
         if (wr_fire && wr_hit) begin
            case (axil_req.awaddr)
               REG_SPI_DATA: spi_data_r <= wr_merge[SPI_WORD_W-1:0];
               REG_SPI_CFG: begin
                  spi_target_r <= wr_merge[0];
                  spi_div_r    <= wr_merge[15:8];
               end
               REG_ATR0:     atr_cfg0 <= wr_merge;
               REG_ATR1:     atr_cfg1 <= wr_merge;
               REG_MISC:     misc_r   <= wr_merge[MISC_W-1:0];
               default:      ;
            endcase
         end
      end
   end

   assign spi_cmd = '{data: spi_data_r, target: spi_target_r, clk_div: spi_div_r};

   assign axil_rsp = '{awready: aw_rdy, wready: aw_rdy, bresp: bresp_r, bvalid: bvalid_r,
                       arready: ar_rdy, rdata: rdata_r, rresp: rresp_r, rvalid: rvalid_r};

endmodule

`default_nettype wire

/* spi/spi_master.sv */
// Mode-0 SPI master, MSB first, one word per spi_start pulse
// Half-period is clk_div+1 bus cycles; enables are active low and one-hot
`timescale 1ns/1ns
`default_nettype none

module spi_master (
   input  wire                                         bus_clk,
   input  wire                                         bus_rst,
   input  wire radio_ctrl_pkg::spi_cmd_t               spi_cmd,
   input  wire                                         spi_start,
   input  wire                                         miso,
   output logic                                        sclk,
   output logic                                        mosi,
   output logic [radio_ctrl_pkg::NUM_SPI_TARGETS-1:0]  sen,
   output logic                                        spi_busy,
   output logic [radio_ctrl_pkg::SPI_WORD_W-1:0]       spi_rx_data
);
   import radio_ctrl_pkg::*;

   logic [SPI_DIV_W-1:0]                div_r;     // Captured divider
   logic [SPI_DIV_W-1:0]                div_cnt;
   logic [$clog2(2*SPI_WORD_W+1)-1:0]   half_cnt;  // Lead-in, 2 per bit, then trail
   logic [SPI_WORD_W-1:0]               tx_shift;
   logic [SPI_WORD_W-1:0]               rx_shift;
   logic                                half_done;

   assign half_done = (div_cnt == div_r);
   assign mosi      = tx_shift[SPI_WORD_W-1];    // MSB first

   ////////////////////
   // Sequencer
   ////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         spi_busy    <= 1'b0;
         sclk        <= 1'b0;
         sen         <= '1;
         div_cnt     <= '0;
         half_cnt    <= '0;
         spi_rx_data <= '0;
      end else if (!spi_busy) begin
         div_cnt  <= '0;
         half_cnt <= '0;
         sclk     <= 1'b0;
         if (spi_start) begin
            spi_busy <= 1'b1;
            sen <= ~(NUM_SPI_TARGETS'(1) << spi_cmd.target);  // Enable drops now
         end
      end else if (half_done) begin
         div_cnt  <= '0;
         half_cnt <= half_cnt + 1'b1;
         if (half_cnt == 2*SPI_WORD_W) begin
            // Trailing half-period over
            spi_busy    <= 1'b0;
            sen         <= '1;
            spi_rx_data <= rx_shift;
         end else begin
            sclk <= ~half_cnt[0];               // Rise after even, fall after odd
         end
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   ////////////////////
   // Shifters
   ////////////////////
   always_ff @(posedge bus_clk) begin
      if (!spi_busy && spi_start) begin
         tx_shift <= spi_cmd.data;
         div_r    <= spi_cmd.clk_div;
      end else if (spi_busy && half_done && half_cnt < 2*SPI_WORD_W) begin
         if (!half_cnt[0]) begin
            rx_shift <= {rx_shift[SPI_WORD_W-2:0], miso};   // Sample on rising sclk
         end else begin
            tx_shift <= {tx_shift[SPI_WORD_W-2:0], 1'b0};   // Next bit on falling sclk
         end
      end
   end

endmodule

`default_nettype wire

/* tb/radio_ctrl_sva.sv */
// Concurrent checks for the radio control plane, bound into radio_ctrl_top
// Small reference models of the ATR and misc outputs are fed from accepted AXI writes
`timescale 1ns/1ns
`default_nettype none

module radio_ctrl_sva (
   input wire                             bus_clk,
   input wire                             bus_rst,
   input wire radio_ctrl_pkg::axil_m2s_t  axil_req,
   input wire radio_ctrl_pkg::axil_s2m_t  axil_rsp,
   input wire                             cat_sen,
   input wire                             cat_sclk,
   input wire                             cat_mosi,
   input wire                             pll_sen,
   input wire                             pll_sclk,
   input wire                             pll_mosi,
   input wire [1:0]                       run_rx,
   input wire [1:0]                       run_tx,
   input wire [7:0]                       fe_atr0,
   input wire [7:0]                       fe_atr1,
   input wire [7:0]                       misc_outs
);
   import radio_ctrl_pkg::*;

   int          err_count = 0;              // Read by the testbench
   logic        wr_acc;
   logic [31:0] atr_shadow0, atr_shadow1;   // Full-strobe writes only
   logic [7:0]  misc_shadow, misc_exp;
   logic [7:0]  atr_exp0, atr_exp1;

   // Idle word in the top byte, full duplex in the bottom byte
   function automatic logic [7:0] pick(input logic [31:0] words, input logic rx, input logic tx);
      return words[8*(3 - {tx, rx}) +: 8];
   endfunction

   assign wr_acc = axil_rsp.awready & axil_req.awvalid & axil_req.wvalid;

   ////////////////////
   // Reference model
   ////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         atr_shadow0 <= '0;
         atr_shadow1 <= '0;
         misc_shadow <= '0;
         misc_exp    <= '0;
         atr_exp0    <= '0;
         atr_exp1    <= '0;
      end else begin
         if (wr_acc && axil_req.awaddr == REG_ATR0) atr_shadow0 <= axil_req.wdata;
         if (wr_acc && axil_req.awaddr == REG_ATR1) atr_shadow1 <= axil_req.wdata;
         if (wr_acc && axil_req.awaddr == REG_MISC) misc_shadow <= axil_req.wdata[7:0];
         misc_exp <= misc_shadow;           // Pins lag the register by one edge
         atr_exp0 <= pick(atr_shadow0, run_rx[0], run_tx[0]);
         atr_exp1 <= pick(atr_shadow1, run_rx[1], run_tx[1]);
      end
   end

   ////////////////////
   // Assertions
   ////////////////////
   a_reset_idle: assert property (@(posedge bus_clk)
      bus_rst |-> !axil_rsp.bvalid && !axil_rsp.rvalid && !axil_rsp.awready
                  && !axil_rsp.wready && !axil_rsp.arready && cat_sen && pll_sen)
      else begin
         $error("bus handshake active or SPI enable low while bus reset is high");
         err_count++;
      end

   a_spi_onehot: assert property (@(posedge bus_clk) cat_sen || pll_sen)
      else begin
         $error("both SPI enables low at the same time");
         err_count++;
      end

   // Deselected target keeps its lines low
   a_spi_idle_lines: assert property (@(posedge bus_clk)
      (!cat_sen || !(cat_sclk || cat_mosi)) && (!pll_sen || !(pll_sclk || pll_mosi)))
      else begin
         $error("sclk or mosi active on a deselected SPI target");
         err_count++;
      end

   a_misc_out: assert property (@(posedge bus_clk) disable iff (bus_rst) misc_outs == misc_exp)
      else begin
         $error("error misc_out: expected %h, actual %h", $sampled(misc_exp), $sampled(misc_outs));
         err_count++;
      end

   a_atr0: assert property (@(posedge bus_clk) disable iff (bus_rst) fe_atr0 == atr_exp0)
      else begin
         $error("error atr_select ch0: expected %h, actual %h", $sampled(atr_exp0),
                $sampled(fe_atr0));
         err_count++;
      end

   a_atr1: assert property (@(posedge bus_clk) disable iff (bus_rst) fe_atr1 == atr_exp1)
      else begin
         $error("error atr_select ch1: expected %h, actual %h", $sampled(atr_exp1),
                $sampled(fe_atr1));
         err_count++;
      end

endmodule

bind radio_ctrl_top radio_ctrl_sva i_sva (.*);

`default_nettype wire

/* tb/tb_radio_ctrl.sv */
// Testbench for the radio control plane
// AXI4-Lite driver tasks, SPI slave model and watchdog; bound assertions do most checks
`timescale 1ns/1ns
`default_nettype none

module tb_radio_ctrl;
   import radio_ctrl_pkg::*;

   localparam int CLK_PERIOD  = 8;
   localparam int XFER_CYCLES = (2*SPI_WORD_W + 1) * 16;   // Divider kept below 16
   localparam int RUN_CYCLES  = 2*(HOLDOFF_CYCLES + 8) + 4*XFER_CYCLES + 40*8 + 16 + 400;

   logic                    bus_clk, reset_global, locked, pll_lock;
   axil_m2s_t               axil_req;
   axil_s2m_t               axil_rsp;
   logic                    cat_miso, cat_sen, cat_mosi, cat_sclk;
   logic                    pll_sen, pll_mosi, pll_sclk;
   logic [NUM_CHANNELS-1:0] run_rx, run_tx;
   logic [ATR_W-1:0]        fe_atr0, fe_atr1;
   logic [MISC_W-1:0]       misc_outs;
   integer                  seed = 56510;
   logic [31:0]             rdata;
   logic [1:0]              resp;
   logic [SPI_WORD_W-1:0]   miso_word, mosi_word;   // SPI model words
   logic                    sel_cat, sel_pll;       // Which enable fell
   int                      bit_idx;

   radio_ctrl_top i_radio_ctrl_top (.*);

   initial bus_clk = 1'b0;
   always #(CLK_PERIOD/2) bus_clk = ~bus_clk;

   ////////////////////
   // Helpers
   ////////////////////
   task automatic stop_on_failure();
      $display("Test failures found");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         stop_on_failure();
      end
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] bresp);
      axil_req.awaddr  = addr;
      axil_req.wdata   = data;
      axil_req.wstrb   = '1;
      axil_req.awvalid = 1'b1;
      axil_req.wvalid  = 1'b1;
      do @(negedge bus_clk); while (!axil_rsp.awready);
      @(negedge bus_clk);                     // Accepted on the edge just passed
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      axil_req.bready  = 1'b1;
      while (!axil_rsp.bvalid) @(negedge bus_clk);
      bresp = axil_rsp.bresp;
      @(negedge bus_clk);
      axil_req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] rresp);
      axil_req.araddr  = addr;
      axil_req.arvalid = 1'b1;
      do @(negedge bus_clk); while (!axil_rsp.arready);
      @(negedge bus_clk);
      axil_req.arvalid = 1'b0;
      axil_req.rready  = 1'b1;
      while (!axil_rsp.rvalid) @(negedge bus_clk);
      data  = axil_rsp.rdata;
      rresp = axil_rsp.rresp;
      @(negedge bus_clk);
      axil_req.rready = 1'b0;
   endtask

   task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input string name);
      axil_write(addr, data, resp);
      check_value(name, exp_resp, resp);
   endtask

   task automatic read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp, input string name);
      axil_read(addr, rdata, resp);
      check_value(name, exp_data, rdata);
      check_value({name, "_resp"}, exp_resp, resp);
   endtask

   ////////////////////
   // SPI slave model
   ////////////////////
   always begin : spi_slave
      @(negedge cat_sen or negedge pll_sen);
      sel_cat   = !cat_sen;
      sel_pll   = !pll_sen;
      miso_word = $random(seed);
      @(negedge bus_clk);
      cat_miso = sel_cat ? miso_word[SPI_WORD_W-1] : 1'b0;   // PLL has no miso
      for (bit_idx = SPI_WORD_W-1; bit_idx >= 0; bit_idx--) begin
         @(posedge cat_sclk or posedge pll_sclk);
         mosi_word[bit_idx] = sel_cat ? cat_mosi : pll_mosi;
         @(negedge cat_sclk or negedge pll_sclk);
         @(negedge bus_clk);
         cat_miso = (sel_cat && bit_idx > 0) ? miso_word[bit_idx-1] : 1'b0;
      end
   end

   // Bound assertion failures end the run here
   always @(negedge bus_clk) begin
      if (i_radio_ctrl_top.i_sva.err_count != 0) begin
         $display("a bound assertion failed");
         stop_on_failure();
      end
   end

   initial begin : watchdog
      #(RUN_CYCLES * CLK_PERIOD);
      $display("timeout: run did not finish within %0d bus cycles", RUN_CYCLES);
      stop_on_failure();
   end

   ////////////////////
   // Stimulus
   ////////////////////
   initial begin : stimulus
      logic [31:0] atr_w0, atr_w1, misc_w, spi_w;
      logic [7:0]  div;
      axil_req     = '0;
      reset_global = 1'b1;
      locked       = 1'b0;
      pll_lock     = 1'b1;
      cat_miso     = 1'b0;
      run_rx       = '0;
      run_tx       = '0;
      repeat (8) @(negedge bus_clk);
      reset_global = 1'b0;
      @(negedge bus_clk);
      locked = 1'b1;                          // Hold-off starts counting

      // Register readback and misc pins
      atr_w0 = $random(seed);
      atr_w1 = $random(seed);
      misc_w = $random(seed);
      write_check(REG_ATR0, atr_w0, RESP_OKAY, "atr0_write");
      write_check(REG_ATR1, atr_w1, RESP_OKAY, "atr1_write");
      write_check(REG_MISC, misc_w, RESP_OKAY, "misc_write");
      read_check(REG_ATR0, atr_w0, RESP_OKAY, "atr0_readback");
      read_check(REG_ATR1, atr_w1, RESP_OKAY, "atr1_readback");
      read_check(REG_MISC, {24'd0, misc_w[7:0]}, RESP_OKAY, "misc_readback");

      // ATR patterns, checked by the bound model
      repeat (16) begin
         @(negedge bus_clk);
         run_rx = $random(seed);
         run_tx = $random(seed);
      end

      // One transfer per target, busy write on the codec pass
      for (int tgt = 0; tgt < NUM_SPI_TARGETS; tgt++) begin
         div   = $random(seed) & 8'h0f;       // Short transfers
         spi_w = $random(seed) & 32'h0000_ffff;
         write_check(REG_SPI_CFG, {16'd0, div, 7'd0, tgt[0]}, RESP_OKAY, "spi_cfg_write");
         write_check(REG_SPI_DATA, spi_w, RESP_OKAY, "spi_start_write");
         if (tgt == 0) begin
            write_check(REG_SPI_DATA, ~spi_w, RESP_SLVERR, "spi_busy_write");
         end
         do begin
            axil_read(REG_STATUS, rdata, resp);
         end while (rdata[0]);
         check_value("spi_mosi_word", spi_w, {16'd0, mosi_word});
         check_value("spi_codec_enable", tgt == 0, sel_cat);
         check_value("spi_pll_enable", tgt == 1, sel_pll);
         read_check(REG_SPI_DATA, (tgt == 0) ? miso_word : 16'd0, RESP_OKAY, "spi_rx_readback");
      end

      // Unmapped addresses
      read_check(8'h0c, 32'd0, RESP_SLVERR, "unmapped_read");
      write_check(8'h20, 32'hffff_ffff, RESP_SLVERR, "unmapped_write");

      // Lock lost in the middle of a slow transfer
      write_check(REG_SPI_CFG, 32'h0000_0f00, RESP_OKAY, "spi_cfg_slow");
      write_check(REG_SPI_DATA, $random(seed), RESP_OKAY, "spi_start_drop");
      repeat (40) @(negedge bus_clk);
      locked = 1'b0;
      repeat (4) @(negedge bus_clk);
      locked = 1'b1;
      read_check(REG_ATR0, 32'd0, RESP_OKAY, "atr0_after_holdoff");   // Waits out hold-off

      @(negedge bus_clk);
      if (i_radio_ctrl_top.i_sva.err_count == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         stop_on_failure();
      end
   end

endmodule

`default_nettype wire
